/* rtl/flit_pkg.sv */
package flit_pkg;

	// network side flit, one 16-bit word per flit
	localparam int FLIT_W = 16;

	// valid flag sits in the top bit
	localparam int FLIT_VALID_BIT = FLIT_W - 1;

	// two flag bits above the payload
	localparam int FLIT_PAYLOAD_W = FLIT_W - 2;

	// field layout, msb first
	// valid marks a flit the router is presenting
	// tail marks the last flit of a packet
	typedef struct packed
	{
		logic                      valid;
		logic                      tail;
		logic [FLIT_PAYLOAD_W-1:0] payload;
	} flit_t;

endpackage

/* rtl/link_pkg.sv */
package link_pkg;

	// locallink data path, two bytes per word
	localparam int LL_D_W = 16;

	// data word, carries one flit bit for bit
	typedef logic [LL_D_W-1:0] ll_word_t;

	// remainder for a word with both bytes valid
	localparam logic LL_REM_FULL = 1'b1;

	// soft error and drop counter
	localparam int ERR_CNT_W = 8;

	typedef logic [ERR_CNT_W-1:0] err_cnt_t;

	// counter sticks here, 255
	localparam err_cnt_t ERR_CNT_MAX = '1;

endpackage

/* rtl/flit_to_ll_tx.sv */
module flit_to_ll_tx
	import flit_pkg::*, link_pkg::*;
(
	input  logic     user_clk_i,
	input  logic     rst_i,
	// network side
	input  flit_t    net_flit_i,
	output logic     net_deq_o,
	// locallink transmit side, active low controls
	input  logic     tx_dst_rdy_n_i,
	output ll_word_t tx_d_o,
	output logic     tx_rem_o,
	output logic     tx_src_rdy_n_o,
	output logic     tx_sof_n_o,
	output logic     tx_eof_n_o
);

	// one-entry holding stage
	ll_word_t held_q;
	logic     full_q;
	logic     xfer;

	// held word leaves when the link is ready
	assign xfer = full_q & ~tx_dst_rdy_n_i;

	// take a valid flit when empty, or when the held word leaves this cycle
	assign net_deq_o = net_flit_i[FLIT_VALID_BIT] & (~full_q | xfer);

	always_ff @(posedge user_clk_i)
	begin
		if (rst_i)
			full_q <= 1'b0;
		else if (net_deq_o)
			full_q <= 1'b1;
		else if (xfer)
			full_q <= 1'b0;
	end

	// payload register, loaded on dequeue only
	always_ff @(posedge user_clk_i)
	begin
		if (net_deq_o)
			held_q <= net_flit_i;
	end

	// every flit is a single word frame
	assign tx_d_o         = held_q;
	assign tx_rem_o       = LL_REM_FULL;
	assign tx_src_rdy_n_o = ~full_q;
	assign tx_sof_n_o     = ~full_q;
	assign tx_eof_n_o     = ~full_q;

	// stalled frame keeps its word and stays presented
	a_hold_stable: assert property (@(posedge user_clk_i) disable iff (rst_i)
		(!tx_src_rdy_n_o && tx_dst_rdy_n_i) |=> (!tx_src_rdy_n_o && $stable(tx_d_o)))
	else
		$error("tx word changed while stalled");

	// router must not lose a flit into a stalled stage
	a_no_deq_stalled: assert property (@(posedge user_clk_i) disable iff (rst_i)
		(!tx_src_rdy_n_o && tx_dst_rdy_n_i) |-> !net_deq_o)
	else
		$error("dequeue while tx stage full and stalled");

endmodule

/* rtl/ll_to_flit_rx.sv */
module ll_to_flit_rx
	import flit_pkg::*, link_pkg::*;
(
	input  logic     user_clk_i,
	input  logic     rst_i,
	// locallink receive side, no back-pressure
	input  ll_word_t rx_d_i,
	input  logic     rx_src_rdy_n_i,
	input  logic     rx_sof_n_i,
	input  logic     rx_eof_n_i,
	// network side
	output logic     net_put_o,
	output flit_t    net_put_flit_o,
	output logic     rx_drop_o
);

	logic  accept;
	logic  good;
	logic  put_q;
	logic  drop_q;
	flit_t flit_q;

	// link presents a word whenever src_rdy is low
	assign accept = ~rx_src_rdy_n_i;

	// a flit is a frame with both marks on the same word
	assign good = accept & ~rx_sof_n_i & ~rx_eof_n_i;

	always_ff @(posedge user_clk_i)
	begin
		if (rst_i)
		begin
			put_q  <= 1'b0;
			drop_q <= 1'b0;
		end
		else
		begin
			put_q  <= good;
			// partial frame, start or end mark missing
			drop_q <= accept & ~good;
		end
	end

	// word passes to the network unchanged
	always_ff @(posedge user_clk_i)
	begin
		if (good)
			flit_q <= rx_d_i;
	end

	assign net_put_o      = put_q;
	assign net_put_flit_o = flit_q;
	assign rx_drop_o      = drop_q;

	a_put_drop_excl: assert property (@(posedge user_clk_i) disable iff (rst_i)
		!(net_put_o && rx_drop_o))
	else
		$error("rx put and drop together");

endmodule

/* rtl/link_status_agg.sv */
module link_status_agg
	import link_pkg::*;
#(
	parameter int N_LINKS = 2
)
(
	input  logic               user_clk_i,
	input  logic               rst_i,
	// per-link status from the serial cores
	input  logic [N_LINKS-1:0] hard_err_i,
	input  logic [N_LINKS-1:0] soft_err_i,
	input  logic [N_LINKS-1:0] frame_err_i,
	input  logic [N_LINKS-1:0] lane_up_i,
	input  logic [N_LINKS-1:0] channel_up_i,
	// malformed word pulses from the receive stages
	input  logic [N_LINKS-1:0] rx_drop_i,
	// merged status
	output logic               hard_err_o,
	output logic               soft_err_o,
	output logic               frame_err_o,
	output logic               channel_up_o,
	output logic [N_LINKS-1:0] lane_up_o,
	output err_cnt_t           err_count_o
);

	// up to two events per link in one cycle
	localparam int INC_W = $clog2(2 * N_LINKS + 1);

	logic [INC_W-1:0]     inc;
	logic [ERR_CNT_W:0]   sum;
	err_cnt_t             cnt_next;

	// count soft errors and drops seen this cycle
	always_comb
	begin
		inc = '0;
		for (int i = 0; i < N_LINKS; i++)
			inc = inc + INC_W'(soft_err_i[i]) + INC_W'(rx_drop_i[i]);
	end

	// one extra bit catches the wrap, then clamp
	assign sum      = {1'b0, err_count_o} + (ERR_CNT_W + 1)'(inc);
	assign cnt_next = sum[ERR_CNT_W] ? ERR_CNT_MAX : sum[ERR_CNT_W-1:0];

	always_ff @(posedge user_clk_i)
	begin
		if (rst_i)
		begin
			hard_err_o   <= 1'b0;
			soft_err_o   <= 1'b0;
			frame_err_o  <= 1'b0;
			channel_up_o <= 1'b0;
			lane_up_o    <= '0;
			err_count_o  <= '0;
		end
		else
		begin
			// any link in error flags the bridge
			hard_err_o   <= |hard_err_i;
			soft_err_o   <= |soft_err_i;
			frame_err_o  <= |frame_err_i;
			// channel is up only when every link is
			channel_up_o <= &channel_up_i;
			lane_up_o    <= lane_up_i;
			err_count_o  <= cnt_next;
		end
	end

	// counter only grows or holds between resets
	a_cnt_monotonic: assert property (@(posedge user_clk_i) disable iff (rst_i)
		1'b1 |=> err_count_o >= $past(err_count_o))
	else
		$error("error count decreased");

endmodule

/* rtl/noc_link_bridge.sv */
module noc_link_bridge
	import flit_pkg::*, link_pkg::*;
#(
	parameter int N_LINKS = 2
)
(
	input  logic               user_clk_i,
	input  logic               rst_i,
	// network to transmit stages
	input  flit_t              net_flit_i        [N_LINKS],
	output logic               net_deq_o         [N_LINKS],
	// locallink transmit
	input  logic               tx_dst_rdy_n_i    [N_LINKS],
	output ll_word_t           tx_d_o            [N_LINKS],
	output logic               tx_rem_o          [N_LINKS],
	output logic               tx_src_rdy_n_o    [N_LINKS],
	output logic               tx_sof_n_o        [N_LINKS],
	output logic               tx_eof_n_o        [N_LINKS],
	// locallink receive
	input  ll_word_t           rx_d_i            [N_LINKS],
	input  logic               rx_src_rdy_n_i    [N_LINKS],
	input  logic               rx_sof_n_i        [N_LINKS],
	input  logic               rx_eof_n_i        [N_LINKS],
	// receive stages to network
	output logic               net_put_o         [N_LINKS],
	output flit_t              net_put_flit_o    [N_LINKS],
	output logic               rx_drop_o         [N_LINKS],
	// per-link status from the serial cores
	input  logic               hard_err_i        [N_LINKS],
	input  logic               soft_err_i        [N_LINKS],
	input  logic               frame_err_i       [N_LINKS],
	input  logic               lane_up_i         [N_LINKS],
	input  logic               channel_up_i      [N_LINKS],
	// merged status
	output logic               hard_err_o,
	output logic               soft_err_o,
	output logic               frame_err_o,
	output logic               channel_up_o,
	output logic [N_LINKS-1:0] lane_up_o,
	output err_cnt_t           err_count_o
);

	// status gathered into vectors for the merge block
	logic [N_LINKS-1:0] hard_err_v;
	logic [N_LINKS-1:0] soft_err_v;
	logic [N_LINKS-1:0] frame_err_v;
	logic [N_LINKS-1:0] lane_up_v;
	logic [N_LINKS-1:0] channel_up_v;
	logic [N_LINKS-1:0] rx_drop_v;

	for (genvar i = 0; i < N_LINKS; i++)
	begin : g_link
		// flit out of the router, one word frame onto the link
		flit_to_ll_tx u_tx
		(
			.user_clk_i     (user_clk_i),
			.rst_i          (rst_i),
			.net_flit_i     (net_flit_i[i]),
			.net_deq_o      (net_deq_o[i]),
			.tx_dst_rdy_n_i (tx_dst_rdy_n_i[i]),
			.tx_d_o         (tx_d_o[i]),
			.tx_rem_o       (tx_rem_o[i]),
			.tx_src_rdy_n_o (tx_src_rdy_n_o[i]),
			.tx_sof_n_o     (tx_sof_n_o[i]),
			.tx_eof_n_o     (tx_eof_n_o[i])
		);

		// one word frame off the link, flit into the router
		ll_to_flit_rx u_rx
		(
			.user_clk_i     (user_clk_i),
			.rst_i          (rst_i),
			.rx_d_i         (rx_d_i[i]),
			.rx_src_rdy_n_i (rx_src_rdy_n_i[i]),
			.rx_sof_n_i     (rx_sof_n_i[i]),
			.rx_eof_n_i     (rx_eof_n_i[i]),
			.net_put_o      (net_put_o[i]),
			.net_put_flit_o (net_put_flit_o[i]),
			.rx_drop_o      (rx_drop_v[i])
		);

		// drop pulse feeds the counter and the port
		assign rx_drop_o[i]    = rx_drop_v[i];
		assign hard_err_v[i]   = hard_err_i[i];
		assign soft_err_v[i]   = soft_err_i[i];
		assign frame_err_v[i]  = frame_err_i[i];
		assign lane_up_v[i]    = lane_up_i[i];
		assign channel_up_v[i] = channel_up_i[i];
	end

	link_status_agg #(
		.N_LINKS (N_LINKS)
	) u_status
	(
		.user_clk_i   (user_clk_i),
		.rst_i        (rst_i),
		.hard_err_i   (hard_err_v),
		.soft_err_i   (soft_err_v),
		.frame_err_i  (frame_err_v),
		.lane_up_i    (lane_up_v),
		.channel_up_i (channel_up_v),
		.rx_drop_i    (rx_drop_v),
		.hard_err_o   (hard_err_o),
		.soft_err_o   (soft_err_o),
		.frame_err_o  (frame_err_o),
		.channel_up_o (channel_up_o),
		.lane_up_o    (lane_up_o),
		.err_count_o  (err_count_o)
	);

endmodule

/* test/tb_noc_link_bridge.sv */
module tb_noc_link_bridge
	import flit_pkg::*, link_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_LINKS    = 2;
	localparam int CLK_PERIOD = 100;
	localparam int RST_CYCLES = 10;
	localparam int TX_FLITS   = 200;
	localparam int RX_CYCLES  = 400;
	localparam int SAT_CYCLES = 150;
	localparam int CNT_SAT    = 255;
	// tx budget of four cycles per flit covers stalls and gaps
	localparam int TEST_CYCLES    = RST_CYCLES + 4 * TX_FLITS + RX_CYCLES + SAT_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	localparam int PH_IDLE    = 0;
	localparam int PH_TRAFFIC = 1;
	localparam int PH_SAT     = 2;

	logic     user_clk_i;
	logic     rst_i;
	flit_t    net_flit_i     [N_LINKS];
	logic     net_deq_o      [N_LINKS];
	logic     tx_dst_rdy_n_i [N_LINKS];
	ll_word_t tx_d_o         [N_LINKS];
	logic     tx_rem_o       [N_LINKS];
	logic     tx_src_rdy_n_o [N_LINKS];
	logic     tx_sof_n_o     [N_LINKS];
	logic     tx_eof_n_o     [N_LINKS];
	ll_word_t rx_d_i         [N_LINKS];
	logic     rx_src_rdy_n_i [N_LINKS];
	logic     rx_sof_n_i     [N_LINKS];
	logic     rx_eof_n_i     [N_LINKS];
	logic     net_put_o      [N_LINKS];
	flit_t    net_put_flit_o [N_LINKS];
	logic     rx_drop_o      [N_LINKS];
	logic     hard_err_a     [N_LINKS];
	logic     soft_err_a     [N_LINKS];
	logic     frame_err_a    [N_LINKS];
	logic     lane_up_a      [N_LINKS];
	logic     channel_up_a   [N_LINKS];
	logic     hard_err_o;
	logic     soft_err_o;
	logic     frame_err_o;
	logic     channel_up_o;
	logic     [N_LINKS-1:0] lane_up_o;
	err_cnt_t err_count_o;

	// status stimulus kept packed, fanned out per link below
	logic [N_LINKS-1:0] hard_err;
	logic [N_LINKS-1:0] soft_err;
	logic [N_LINKS-1:0] frame_err;
	logic [N_LINKS-1:0] lane_up;
	logic [N_LINKS-1:0] channel_up;

	// reference model state
	flit_t              tx_q [N_LINKS][$];
	ll_word_t           rx_q [N_LINKS][$];
	ll_word_t           tx_exp [N_LINKS];
	ll_word_t           rx_exp [N_LINKS];
	logic [N_LINKS-1:0] tx_have;
	logic [N_LINKS-1:0] put_due;
	logic [N_LINKS-1:0] drop_due;
	err_cnt_t           exp_cnt;
	int                 tx_taken [N_LINKS];
	int                 tx_sent  [N_LINKS];
	int                 rx_puts  [N_LINKS];
	int                 rx_cycles;
	int                 phase;
	int                 errors;
	int                 cycle_cnt;
	logic [31:0]        seed;
	logic               reset_ok;

	noc_link_bridge #(
		.N_LINKS (N_LINKS)
	) u_dut
	(
		.user_clk_i     (user_clk_i),
		.rst_i          (rst_i),
		.net_flit_i     (net_flit_i),
		.net_deq_o      (net_deq_o),
		.tx_dst_rdy_n_i (tx_dst_rdy_n_i),
		.tx_d_o         (tx_d_o),
		.tx_rem_o       (tx_rem_o),
		.tx_src_rdy_n_o (tx_src_rdy_n_o),
		.tx_sof_n_o     (tx_sof_n_o),
		.tx_eof_n_o     (tx_eof_n_o),
		.rx_d_i         (rx_d_i),
		.rx_src_rdy_n_i (rx_src_rdy_n_i),
		.rx_sof_n_i     (rx_sof_n_i),
		.rx_eof_n_i     (rx_eof_n_i),
		.net_put_o      (net_put_o),
		.net_put_flit_o (net_put_flit_o),
		.rx_drop_o      (rx_drop_o),
		.hard_err_i     (hard_err_a),
		.soft_err_i     (soft_err_a),
		.frame_err_i    (frame_err_a),
		.lane_up_i      (lane_up_a),
		.channel_up_i   (channel_up_a),
		.hard_err_o     (hard_err_o),
		.soft_err_o     (soft_err_o),
		.frame_err_o    (frame_err_o),
		.channel_up_o   (channel_up_o),
		.lane_up_o      (lane_up_o),
		.err_count_o    (err_count_o)
	);

	always #(CLK_PERIOD / 2) user_clk_i = ~user_clk_i;

	// lcg, numerical recipes constants
	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic void flag_mismatch(input string what);
		errors++;
		$display("MISMATCH at %0t: %s", $time, what);
	endfunction

	function automatic bit traffic_done();
		bit done;
		done = (rx_cycles >= RX_CYCLES);
		for (int l = 0; l < N_LINKS; l++)
			done = done && (tx_sent[l] >= TX_FLITS);
		return done;
	endfunction

	task automatic end_run(input bit timed_out);
		int tx_total;
		int rx_total;
		tx_total = 0;
		rx_total = 0;
		for (int l = 0; l < N_LINKS; l++)
		begin
			tx_total += tx_sent[l];
			rx_total += rx_puts[l];
		end
		$display("summary: %0d errors, %0d tx words, %0d rx puts, %0d cycles",
			errors, tx_total, rx_total, cycle_cnt);
		if (errors == 0 && !timed_out)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	endtask

	// model update on pre-edge values, then next stimulus
	always @(posedge user_clk_i)
	begin : stim
		logic [31:0] r;
		logic [31:0] c;
		logic        deq;
		logic        good;
		logic        bad;
		int          sum;
		if (rst_i)
		begin
			for (int l = 0; l < N_LINKS; l++)
			begin
				tx_q[l].delete();
				rx_q[l].delete();
			end
			tx_have  <= '0;
			put_due  <= '0;
			drop_due <= '0;
			exp_cnt  <= '0;
		end
		else
		begin
			// soft errors and drops seen now land in the count next cycle
			sum = int'(exp_cnt) + $countones(soft_err) + $countones(drop_due);
			exp_cnt <= (sum > CNT_SAT) ? err_cnt_t'(CNT_SAT) : err_cnt_t'(sum);
			for (int l = 0; l < N_LINKS; l++)
			begin
				// flit taken when valid and the stage is empty or draining
				deq = net_flit_i[l].valid
					&& (tx_q[l].size() == 0 || !tx_dst_rdy_n_i[l]);
				// word left on the link
				if (tx_q[l].size() != 0 && !tx_dst_rdy_n_i[l])
				begin
					void'(tx_q[l].pop_front());
					tx_sent[l]++;
				end
				if (deq)
				begin
					tx_q[l].push_back(net_flit_i[l]);
					tx_taken[l]++;
				end
				tx_have[l] <= (tx_q[l].size() != 0);
				tx_exp[l]  <= (tx_q[l].size() != 0) ? ll_word_t'(tx_q[l][0]) : '0;
				// put owed for the good frame of the last cycle
				if (put_due[l] && rx_q[l].size() != 0)
				begin
					void'(rx_q[l].pop_front());
					rx_puts[l]++;
				end
				good = !rx_src_rdy_n_i[l] && !rx_sof_n_i[l] && !rx_eof_n_i[l];
				bad  = !rx_src_rdy_n_i[l] && !good;
				if (good)
					rx_q[l].push_back(rx_d_i[l]);
				put_due[l]  <= good;
				drop_due[l] <= bad;
				rx_exp[l]   <= (rx_q[l].size() != 0) ? rx_q[l][0] : '0;
			end
		end

		for (int l = 0; l < N_LINKS; l++)
		begin
			if (phase == PH_TRAFFIC)
			begin
				r = next_random();
				c = next_random();
				// stall one cycle in four
				tx_dst_rdy_n_i[l] <= (c[31:30] == 2'b00);
				// network holds a valid flit until it is taken
				if (net_deq_o[l] || !net_flit_i[l].valid)
				begin
					if (tx_taken[l] < TX_FLITS && c[29:28] != 2'b00)
						net_flit_i[l] <= flit_t'({1'b1, r[30:16]});
					else
						net_flit_i[l] <= flit_t'({1'b0, r[30:16]});
				end
				// rx mix: half idle, three eighths good, one eighth malformed
				r = next_random();
				c = next_random();
				rx_d_i[l] <= r[31:16];
				if (rx_cycles >= RX_CYCLES || c[31:29] < 3'd4)
				begin
					rx_src_rdy_n_i[l] <= 1'b1;
					rx_sof_n_i[l]     <= c[28];
					rx_eof_n_i[l]     <= c[27];
				end
				else if (c[31:29] != 3'd7)
				begin
					rx_src_rdy_n_i[l] <= 1'b0;
					rx_sof_n_i[l]     <= 1'b0;
					rx_eof_n_i[l]     <= 1'b0;
				end
				else
				begin
					// at least one mark missing
					rx_src_rdy_n_i[l] <= 1'b0;
					rx_sof_n_i[l]     <= c[28];
					rx_eof_n_i[l]     <= ~c[28] | c[27];
				end
				c = next_random();
				hard_err[l]   <= (c[31:28] == 4'd0);
				soft_err[l]   <= (c[27:24] == 4'd0);
				frame_err[l]  <= (c[23:20] == 4'd0);
				lane_up[l]    <= (c[19:17] != 3'd0);
				channel_up[l] <= (c[16:14] != 3'd0);
			end
			else
			begin
				net_flit_i[l]     <= '0;
				tx_dst_rdy_n_i[l] <= 1'b0;
				rx_src_rdy_n_i[l] <= 1'b1;
				rx_sof_n_i[l]     <= 1'b1;
				rx_eof_n_i[l]     <= 1'b1;
				hard_err[l]       <= 1'b0;
				soft_err[l]       <= (phase == PH_SAT);
				frame_err[l]      <= 1'b0;
				lane_up[l]        <= (phase == PH_SAT);
				channel_up[l]     <= (phase == PH_SAT);
			end
		end
		if (phase == PH_TRAFFIC && rx_cycles < RX_CYCLES)
			rx_cycles++;
	end

	always_comb
	begin
		reset_ok = !hard_err_o && !soft_err_o && !frame_err_o && !channel_up_o
			&& lane_up_o == '0 && err_count_o == '0;
		for (int l = 0; l < N_LINKS; l++)
			reset_ok = reset_ok && !net_deq_o[l] && !net_put_o[l] && !rx_drop_o[l]
				&& tx_src_rdy_n_o[l] && tx_sof_n_o[l] && tx_eof_n_o[l];
	end

	for (genvar l = 0; l < N_LINKS; l++)
	begin : g_link
		assign hard_err_a[l]   = hard_err[l];
		assign soft_err_a[l]   = soft_err[l];
		assign frame_err_a[l]  = frame_err[l];
		assign lane_up_a[l]    = lane_up[l];
		assign channel_up_a[l] = channel_up[l];

		// transferred word is the oldest flit, framed as one full word
		a_tx_word: assert property (@(posedge user_clk_i) disable iff (rst_i)
			(!tx_src_rdy_n_o[l] && !tx_dst_rdy_n_i[l]) |-> (tx_d_o[l] == tx_exp[l]
			&& !tx_sof_n_o[l] && !tx_eof_n_o[l] && tx_rem_o[l] == 1'b1))
		else
			flag_mismatch($sformatf("link %0d tx word or framing wrong", l));

		// presented exactly while a taken flit is still owed
		a_tx_occupied: assert property (@(posedge user_clk_i) disable iff (rst_i)
			tx_src_rdy_n_o[l] == !tx_have[l])
		else
			flag_mismatch($sformatf("link %0d tx flit lost or duplicated", l));

		a_tx_hold: assert property (@(posedge user_clk_i) disable iff (rst_i)
			(!tx_src_rdy_n_o[l] && tx_dst_rdy_n_i[l]) |=> (!tx_src_rdy_n_o[l]
			&& $stable(tx_d_o[l]) && $stable(tx_sof_n_o[l]) && $stable(tx_eof_n_o[l])
			&& $stable(tx_rem_o[l])))
		else
			flag_mismatch($sformatf("link %0d tx frame changed under stall", l));

		// dequeue exactly when valid and the model stage is empty or draining
		a_tx_deq: assert property (@(posedge user_clk_i) disable iff (rst_i)
			net_deq_o[l] == (net_flit_i[l].valid
			&& (!tx_have[l] || !tx_dst_rdy_n_i[l])))
		else
			flag_mismatch($sformatf("link %0d net_deq_o wrong", l));

		a_rx_put: assert property (@(posedge user_clk_i) disable iff (rst_i)
			net_put_o[l] == put_due[l])
		else
			flag_mismatch($sformatf("link %0d net_put_o wrong", l));

		a_rx_data: assert property (@(posedge user_clk_i) disable iff (rst_i)
			put_due[l] |-> ll_word_t'(net_put_flit_o[l]) == rx_exp[l])
		else
			flag_mismatch($sformatf("link %0d put flit differs from frame", l));

		a_rx_drop: assert property (@(posedge user_clk_i) disable iff (rst_i)
			rx_drop_o[l] == drop_due[l])
		else
			flag_mismatch($sformatf("link %0d rx_drop_o wrong", l));
	end

	a_reset: assert property (@(posedge user_clk_i) $past(rst_i) |-> reset_ok)
	else
		flag_mismatch("outputs not idle in or just after reset");

	a_err_flags: assert property (@(posedge user_clk_i) disable iff (rst_i)
		{hard_err_o, soft_err_o, frame_err_o} == $past({|hard_err, |soft_err, |frame_err}))
	else
		flag_mismatch("merged error flags wrong");

	a_link_up: assert property (@(posedge user_clk_i) disable iff (rst_i)
		channel_up_o == $past(&channel_up) && lane_up_o == $past(lane_up))
	else
		flag_mismatch("lane or channel status wrong");

	a_err_count: assert property (@(posedge user_clk_i) disable iff (rst_i)
		err_count_o == exp_cnt)
	else
		flag_mismatch($sformatf("err_count_o %0d, expected %0d", err_count_o, exp_cnt));

	// hang guard
	always @(posedge user_clk_i)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES)
		begin
			$display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
			end_run(1'b1);
		end
	end

	initial
	begin
		user_clk_i = 1'b0;
		rst_i      = 1'b1;
		seed       = 32'h6aad;
		phase      = PH_IDLE;
		errors     = 0;
		cycle_cnt  = 0;
		rx_cycles  = 0;
		hard_err   = '0;
		soft_err   = '0;
		frame_err  = '0;
		lane_up    = '0;
		channel_up = '0;
		for (int l = 0; l < N_LINKS; l++)
		begin
			net_flit_i[l]     = '0;
			tx_dst_rdy_n_i[l] = 1'b1;
			rx_d_i[l]         = '0;
			rx_src_rdy_n_i[l] = 1'b1;
			rx_sof_n_i[l]     = 1'b1;
			rx_eof_n_i[l]     = 1'b1;
			tx_taken[l]       = 0;
			tx_sent[l]        = 0;
			rx_puts[l]        = 0;
		end
		repeat (RST_CYCLES) @(posedge user_clk_i);
		rst_i <= 1'b0;
		// one quiet cycle so the post-reset state is seen
		@(posedge user_clk_i);
		phase <= PH_TRAFFIC;
		while (!traffic_done())
			@(posedge user_clk_i);
		// both links in soft error, count runs into 255
		phase <= PH_SAT;
		repeat (SAT_CYCLES) @(posedge user_clk_i);
		phase <= PH_IDLE;
		repeat (4) @(posedge user_clk_i);
		for (int l = 0; l < N_LINKS; l++)
		begin
			assert (tx_sent[l] == TX_FLITS && tx_q[l].size() == 0)
			else
				flag_mismatch($sformatf("link %0d sent %0d of %0d flits",
					l, tx_sent[l], TX_FLITS));
			assert (rx_q[l].size() == 0)
			else
				flag_mismatch($sformatf("link %0d has good frames without put", l));
		end
		assert (err_count_o == err_cnt_t'(CNT_SAT))
		else
			flag_mismatch($sformatf("err_count_o %0d, expected saturation", err_count_o));
		end_run(1'b0);
	end

endmodule

/* vlog.f */
rtl/flit_pkg.sv
rtl/link_pkg.sv
rtl/flit_to_ll_tx.sv
rtl/ll_to_flit_rx.sv
rtl/link_status_agg.sv
rtl/noc_link_bridge.sv
test/tb_noc_link_bridge.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := tb_noc_link_bridge
FILELIST := vlog.f
OBJ_DIR  := obj_dir
PASS_MSG := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# the run passes only if the pass line shows up in the output
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
